// ==== filelist.f ====
+incdir+include
logic/decode_pkg.sv
logic/instr_decoder.sv
logic/operand_select.sv
logic/fence_fsm.sv
logic/credit_counter.sv
logic/dispatch_reg.sv
logic/decode_top.sv
testbench/tb_clock.sv
testbench/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_tb -f filelist.f -o decode_sim

out=$(./obj_dir/decode_sim)
echo "$out"

# the run passes only if the testbench printed its pass message
echo "$out" | grep -q "Test completed successfully"

// ==== testbench/decode_tb.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_tb
  import decode_pkg::*;
;

  typedef struct packed {
    unit_e  unit;
    issue_t iss;
  } exp_t;

  logic                   CLK, nRST, fetch_valid, fetch_ready;
  instr_u                 fetch_instr;
  logic [`XLEN_W-1:0]     fetch_pc, rs1_data, rs2_data;
  logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  issue_t                 issue;
  logic                   arith_valid, lsu_valid, arith_credit, lsu_credit;
  logic                   icache_flush, dcache_flush, icache_done, dcache_done;
  exp_t                   cur_exp, head;
  logic                   cur_fence, auto_return, fence_pending, i_seen, d_seen, issue_seen;
  logic [`TAG_W-1:0]      exp_tag;
  int                     arith_cnt, lsu_cnt, err_count, issue_count;
  exp_t                   exp_q[$];

  tb_clock u_clock (.CLK(CLK));

  decode_top decode_top_inst (.*);

  function automatic logic [31:0] reg_value(input logic [4:0] n);
    return {27'b0, n} * 32'h01010101;
  endfunction

  // register file read is combinational
  assign rs1_data   = reg_value(rs1_addr);
  assign rs2_data   = reg_value(rs2_addr);
  assign issue_seen = arith_valid || lsu_valid;

  // rv32i table indexed by funct3, bit 30 turns add into sub and srl into sra
  function automatic alu_op_e rv32i_alu_op(input logic [31:0] w);
    alu_op_e by_funct3[8];
    by_funct3 = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    if (w[6:0] == `OPC_OP && w[14:12] == 3'd0 && w[30]) return SUB;
    if (w[14:12] == 3'd5 && w[30]) return SRA;
    return by_funct3[w[14:12]];
  endfunction

  function automatic exp_t expect_for(input logic [31:0] w, input logic [31:0] pc);
    exp_t        e;
    logic [31:0] imm_i, imm_s, imm_u;
    e = '0;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_u = {w[31:12], 12'b0};
    e.unit = UNIT_ARITH;
    e.iss.pc = pc;
    e.iss.rd = w[11:7];
    e.iss.alu_op = ADD;
    e.iss.port_a = reg_value(w[19:15]);
    case (w[6:0])
      `OPC_OP: begin
        e.iss.port_b = reg_value(w[24:20]);
        e.iss.alu_op = rv32i_alu_op(w);
        e.iss.wen = 1'b1;
      end
      `OPC_OP_IMM: begin
        e.iss.port_b = (w[13:12] == 2'b01) ? {27'b0, w[24:20]} : imm_i;
        e.iss.alu_op = rv32i_alu_op(w);
        e.iss.wen = 1'b1;
      end
      `OPC_LUI, `OPC_AUIPC: begin
        e.iss.port_a = (w[6:0] == `OPC_LUI) ? 32'h0 : pc;
        e.iss.port_b = imm_u;
        e.iss.wen = 1'b1;
      end
      `OPC_LOAD: begin
        e.unit = UNIT_LSU;
        e.iss.port_b = imm_i;
        e.iss.wen = 1'b1;
        e.iss.mem_read = 1'b1;
        e.iss.mem_size = w[14:12];
      end
      `OPC_STORE: begin
        e.unit = UNIT_LSU;
        e.iss.port_b = imm_s;
        e.iss.store_data = reg_value(w[24:20]);
        e.iss.rd = '0;
        e.iss.mem_write = 1'b1;
        e.iss.mem_size = w[14:12];
      end
      default: e.iss.illegal = 1'b1;
    endcase
    return e;
  endfunction

  // mirror of accepts, credits and fence progress
  always @(posedge CLK or negedge nRST) begin
    exp_t entry;
    if (!nRST) begin
      arith_cnt <= `ARITH_CREDITS;
      lsu_cnt <= `LSU_CREDITS;
      exp_tag <= '0;
      fence_pending <= 1'b0;
      i_seen <= 1'b0;
      d_seen <= 1'b0;
    end else begin
      arith_cnt <= arith_cnt + int'(arith_credit) -
                   int'(fetch_valid && fetch_ready && !cur_fence && cur_exp.unit == UNIT_ARITH);
      lsu_cnt <= lsu_cnt + int'(lsu_credit) -
                 int'(fetch_valid && fetch_ready && !cur_fence && cur_exp.unit == UNIT_LSU);
      if (fetch_valid && fetch_ready && cur_fence) begin
        fence_pending <= 1'b1;
        i_seen <= 1'b0;
        d_seen <= 1'b0;
      end else begin
        if (icache_done) i_seen <= 1'b1;
        if (dcache_done) d_seen <= 1'b1;
        if (i_seen && d_seen) fence_pending <= 1'b0;
      end
      if (fetch_valid && fetch_ready && !cur_fence) begin
        entry = cur_exp;
        entry.iss.tag = exp_tag;
        exp_q.push_back(entry);
        exp_tag <= exp_tag + 1'b1;
      end
    end
  end

  // the head entry is in place before the edge that checks the issue
  always @(negedge CLK) begin
    if (issue_seen) begin
      if (exp_q.size() == 0) begin
        err_count++;
        $display("issue valid seen with no instruction outstanding");
      end else begin
        head <= exp_q.pop_front();
        issue_count++;
      end
    end
  end

  always @(negedge CLK) begin
    arith_credit = 1'b0;
    lsu_credit = 1'b0;
    if (auto_return && nRST) begin
      if (arith_cnt < `ARITH_CREDITS && $urandom % 3 == 0) arith_credit = 1'b1;
      if (lsu_cnt < `LSU_CREDITS && $urandom % 3 == 0) lsu_credit = 1'b1;
    end
  end

  a_reset_quiet: assert property (@(posedge CLK)
    !nRST |-> !arith_valid && !lsu_valid && !icache_flush && !fetch_ready)
    else begin err_count++; $display("outputs active during reset"); end
  a_issue_latency: assert property (@(posedge CLK) disable iff (!nRST)
    fetch_valid && fetch_ready && !cur_fence |=> issue_seen)
    else begin err_count++; $display("no issue valid in the cycle after acceptance"); end
  a_unit: assert property (@(posedge CLK) disable iff (!nRST)
    issue_seen |-> lsu_valid == (head.unit == UNIT_LSU))
    else begin err_count++; $display("[ERROR] lsu_valid expected %h got %h",
      head.unit == UNIT_LSU, lsu_valid); end
  a_tag: assert property (@(posedge CLK) disable iff (!nRST)
    issue_seen |-> issue.tag == head.iss.tag)
    else begin err_count++; $display("[ERROR] issue.tag expected %h got %h",
      head.iss.tag, issue.tag); end
  a_pc: assert property (@(posedge CLK) disable iff (!nRST)
    issue_seen |-> issue.pc == head.iss.pc)
    else begin err_count++; $display("[ERROR] issue.pc expected %h got %h",
      head.iss.pc, issue.pc); end
  a_port_a: assert property (@(posedge CLK) disable iff (!nRST)
    issue_seen && !head.iss.illegal |-> issue.port_a == head.iss.port_a)
    else begin err_count++; $display("[ERROR] issue.port_a expected %h got %h",
      head.iss.port_a, issue.port_a); end
  a_port_b: assert property (@(posedge CLK) disable iff (!nRST)
    issue_seen && !head.iss.illegal |-> issue.port_b == head.iss.port_b)
    else begin err_count++; $display("[ERROR] issue.port_b expected %h got %h",
      head.iss.port_b, issue.port_b); end
  a_alu_op: assert property (@(posedge CLK) disable iff (!nRST)
    arith_valid && !head.iss.illegal |-> issue.alu_op == head.iss.alu_op)
    else begin err_count++; $display("[ERROR] issue.alu_op expected %h got %h",
      head.iss.alu_op, issue.alu_op); end
  a_flags: assert property (@(posedge CLK) disable iff (!nRST)
    issue_seen |-> {issue.wen, issue.illegal, issue.mem_read, issue.mem_write} ==
                   {head.iss.wen, head.iss.illegal, head.iss.mem_read, head.iss.mem_write})
    else begin err_count++; $display("[ERROR] wen/illegal/mem_read/mem_write expected %h got %h",
      {head.iss.wen, head.iss.illegal, head.iss.mem_read, head.iss.mem_write},
      {issue.wen, issue.illegal, issue.mem_read, issue.mem_write}); end
  a_rd: assert property (@(posedge CLK) disable iff (!nRST)
    issue_seen && head.iss.wen |-> issue.rd == head.iss.rd)
    else begin err_count++; $display("[ERROR] issue.rd expected %h got %h",
      head.iss.rd, issue.rd); end
  a_mem_size: assert property (@(posedge CLK) disable iff (!nRST)
    lsu_valid |-> issue.mem_size == head.iss.mem_size)
    else begin err_count++; $display("[ERROR] issue.mem_size expected %h got %h",
      head.iss.mem_size, issue.mem_size); end
  a_store_data: assert property (@(posedge CLK) disable iff (!nRST)
    lsu_valid && head.iss.mem_write |-> issue.store_data == head.iss.store_data)
    else begin err_count++; $display("[ERROR] issue.store_data expected %h got %h",
      head.iss.store_data, issue.store_data); end
  a_no_credit_stall: assert property (@(posedge CLK) disable iff (!nRST)
    fetch_valid && !cur_fence &&
    ((cur_exp.unit == UNIT_ARITH) ? arith_cnt : lsu_cnt) == 0 |-> !fetch_ready)
    else begin err_count++; $display("fetch accepted with no credit left for the unit"); end
  a_fence_flush: assert property (@(posedge CLK) disable iff (!nRST)
    fetch_valid && fetch_ready && cur_fence |=>
      icache_flush && dcache_flush && !issue_seen ##1 !icache_flush && !dcache_flush)
    else begin err_count++; $display("fence flush pulse wrong or fence issued"); end
  a_fence_hold: assert property (@(posedge CLK) disable iff (!nRST)
    fence_pending |-> !fetch_ready)
    else begin err_count++; $display("fetch_ready rose before both flushes completed"); end

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test failed");
    $finish;
  endtask

  task automatic send(input logic [31:0] w, input logic [31:0] pc);
    int n;
    @(negedge CLK);
    fetch_valid = 1'b1;
    fetch_instr = w;
    fetch_pc = pc;
    cur_fence = (w[6:0] == `OPC_MISC_MEM);
    cur_exp = expect_for(w, pc);
    n = 0;
    #1;
    while (!fetch_ready) begin
      n++;
      if (n > 200) give_up("fetch_ready");
      @(negedge CLK);
      #1;
    end
    @(posedge CLK);
  endtask

  task automatic idle_until_drained();
    int n;
    @(negedge CLK);
    fetch_valid = 1'b0;
    n = 0;
    while (exp_q.size() != 0 || issue_seen || arith_cnt != `ARITH_CREDITS ||
           lsu_cnt != `LSU_CREDITS) begin
      n++;
      if (n > 200) give_up("issue queue and credits to drain");
      @(negedge CLK);
    end
  endtask

  function automatic logic [31:0] random_arith();
    logic [31:0] w;
    logic [2:0]  f3;
    w = $urandom;
    f3 = w[14:12];
    case ($urandom % 4)
      0: begin
        w[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, w[30], 5'b0} : 7'b0;
        w[6:0] = `OPC_OP;
      end
      1: begin
        if (f3 == 3'd1) w[31:25] = 7'b0;
        if (f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
        w[6:0] = `OPC_OP_IMM;
      end
      2: w[6:0] = `OPC_LUI;
      default: w[6:0] = `OPC_AUIPC;
    endcase
    return w;
  endfunction

  function automatic logic [31:0] random_mem();
    logic [31:0] w;
    w = $urandom;
    if ($urandom % 2 == 0) begin
      w[14:12] = (w[14:12] == 3'd3 || w[14:12] > 3'd5) ? 3'd2 : w[14:12];
      w[6:0] = `OPC_LOAD;
    end else begin
      w[14:12] = {1'b0, w[13:12] == 2'b11 ? 2'b10 : w[13:12]};
      w[6:0] = `OPC_STORE;
    end
    return w;
  endfunction

  task automatic run_fence(input logic [31:0] pc);
    int di, dd, k;
    send({17'b0, 3'b000, 5'b0, `OPC_MISC_MEM}, pc);
    di = $urandom % 7;
    dd = $urandom % 7;
    for (k = 0; k <= 6; k++) begin
      @(negedge CLK);
      fetch_valid = 1'b0;
      icache_done = (k == di);
      dcache_done = (k == dd);
    end
    @(negedge CLK);
    icache_done = 1'b0;
    dcache_done = 1'b0;
    k = 0;
    while (!fetch_ready) begin
      k++;
      if (k > 20) give_up("fetch_ready after fence");
      @(negedge CLK);
    end
  endtask

  initial begin
    void'($urandom(7205));
    nRST = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    fetch_pc = '0;
    icache_done = 1'b0;
    dcache_done = 1'b0;
    arith_credit = 1'b0;
    lsu_credit = 1'b0;
    cur_fence = 1'b0;
    cur_exp = '0;
    head = '0;
    auto_return = 1'b1;
    err_count = 0;
    issue_count = 0;
    repeat (10) @(negedge CLK);
    nRST = 1'b1;
    for (int i = 0; i < 40; i++) send(random_arith(), 32'h1000 + 4 * i);
    for (int i = 0; i < 30; i++) send(random_mem(), 32'h2000 + 4 * i);
    for (int i = 0; i < 30; i++) begin
      send(($urandom % 2 == 0) ? random_arith() : random_mem(), 32'h3000 + 4 * i);
    end
    // exhaust each unit's credits, then release them late
    idle_until_drained();
    auto_return = 1'b0;
    for (int i = 0; i < `ARITH_CREDITS; i++) send(random_arith(), 32'h4000 + 4 * i);
    fork
      begin
        repeat (8) @(negedge CLK);
        auto_return = 1'b1;
      end
    join_none
    send(random_arith(), 32'h4100);
    idle_until_drained();
    auto_return = 1'b0;
    for (int i = 0; i < `LSU_CREDITS; i++) send(random_mem(), 32'h5000 + 4 * i);
    fork
      begin
        repeat (8) @(negedge CLK);
        auto_return = 1'b1;
      end
    join_none
    send(random_mem(), 32'h5100);
    idle_until_drained();
    for (int i = 0; i < 4; i++) begin
      send(random_arith(), 32'h6000 + 16 * i);
      run_fence(32'h6004 + 16 * i);
      send(random_mem(), 32'h6008 + 16 * i);
    end
    for (int i = 0; i < 3; i++) send({$urandom} | 32'h7f, 32'h7000 + 4 * i);
    idle_until_drained();
    $display("errors: %0d, issues checked: %0d", err_count, issue_count);
    if (err_count == 0 && issue_count > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 10
) (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
  end

  always #(HALF_PERIOD_NS) CLK = ~CLK;

endmodule

// ==== logic/decode_top.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_top
  import decode_pkg::*;
(
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    fetch_valid,
  input  instr_u                  fetch_instr,
  input  logic [`XLEN_W-1:0]      fetch_pc,
  output logic                    fetch_ready,
  output logic [`REG_ADDR_W-1:0]  rs1_addr,
  output logic [`REG_ADDR_W-1:0]  rs2_addr,
  input  logic [`XLEN_W-1:0]      rs1_data,
  input  logic [`XLEN_W-1:0]      rs2_data,
  output issue_t                  issue,
  output logic                    arith_valid,
  output logic                    lsu_valid,
  input  logic                    arith_credit,
  input  logic                    lsu_credit,
  output logic                    icache_flush,
  output logic                    dcache_flush,
  input  logic                    icache_done,
  input  logic                    dcache_done
);

  decode_ctrl_t       ctrl;
  logic [`XLEN_W-1:0] imm;
  logic [`XLEN_W-1:0] port_a;
  logic [`XLEN_W-1:0] port_b;
  logic [`XLEN_W-1:0] store_data;
  logic               run;
  logic               flush_pulse;
  logic               accept;
  logic               arith_has_credit;
  logic               lsu_has_credit;
  logic               target_has_credit;
  logic               arith_consume;
  logic               lsu_consume;

  instr_decoder u_decoder (
    .instr (fetch_instr),
    .ctrl  (ctrl),
    .imm   (imm)
  );

  assign rs1_addr = ctrl.rs1;
  assign rs2_addr = ctrl.rs2;

  operand_select u_operands (
    .ctrl       (ctrl),
    .imm        (imm),
    .pc         (fetch_pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .port_a     (port_a),
    .port_b     (port_b),
    .store_data (store_data)
  );

  // fence needs no credit, everything else needs one from its unit
  assign target_has_credit = ctrl.is_fence ||
                             ((ctrl.unit == UNIT_ARITH) ? arith_has_credit : lsu_has_credit);
  assign fetch_ready   = run && target_has_credit;
  assign accept        = fetch_valid && fetch_ready;
  assign arith_consume = accept && !ctrl.is_fence && (ctrl.unit == UNIT_ARITH);
  assign lsu_consume   = accept && !ctrl.is_fence && (ctrl.unit == UNIT_LSU);

  fence_fsm u_fence (
    .CLK         (CLK),
    .nRST        (nRST),
    .accept      (accept),
    .is_fence    (ctrl.is_fence),
    .icache_done (icache_done),
    .dcache_done (dcache_done),
    .flush_pulse (flush_pulse),
    .run         (run)
  );

  assign icache_flush = flush_pulse;
  assign dcache_flush = flush_pulse;

  credit_counter #(.INIT_CREDITS(`ARITH_CREDITS)) u_arith_credits (
    .CLK        (CLK),
    .nRST       (nRST),
    .consume    (arith_consume),
    .give_back  (arith_credit),
    .has_credit (arith_has_credit)
  );

  credit_counter #(.INIT_CREDITS(`LSU_CREDITS)) u_lsu_credits (
    .CLK        (CLK),
    .nRST       (nRST),
    .consume    (lsu_consume),
    .give_back  (lsu_credit),
    .has_credit (lsu_has_credit)
  );

  dispatch_reg u_dispatch (
    .CLK         (CLK),
    .nRST        (nRST),
    .accept      (accept),
    .ctrl        (ctrl),
    .pc          (fetch_pc),
    .port_a      (port_a),
    .port_b      (port_b),
    .store_data  (store_data),
    .issue       (issue),
    .arith_valid (arith_valid),
    .lsu_valid   (lsu_valid)
  );

endmodule

// ==== logic/dispatch_reg.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module dispatch_reg
  import decode_pkg::*;
(
  input  logic               CLK,
  input  logic               nRST,
  input  logic               accept,
  input  decode_ctrl_t       ctrl,
  input  logic [`XLEN_W-1:0] pc,
  input  logic [`XLEN_W-1:0] port_a,
  input  logic [`XLEN_W-1:0] port_b,
  input  logic [`XLEN_W-1:0] store_data,
  output issue_t             issue,
  output logic               arith_valid,
  output logic               lsu_valid
);

  logic [`TAG_W-1:0] tag;
  logic              load;

  // fences never reach an execution unit
  assign load = accept && !ctrl.is_fence;

  // completion tag rotates across both units
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      tag         <= '0;
      arith_valid <= 1'b0;
      lsu_valid   <= 1'b0;
    end else if (load) begin
      tag         <= tag + 1'b1;
      arith_valid <= (ctrl.unit == UNIT_ARITH);
      lsu_valid   <= (ctrl.unit == UNIT_LSU);
    end else begin
      arith_valid <= 1'b0;
      lsu_valid   <= 1'b0;
    end
  end

  // issue payload, qualified by the valids
  always_ff @(posedge CLK) begin
    if (load) begin
      issue.tag        <= tag;
      issue.pc         <= pc;
      issue.port_a     <= port_a;
      issue.port_b     <= port_b;
      issue.store_data <= store_data;
      issue.alu_op     <= ctrl.alu_op;
      issue.rd         <= ctrl.rd;
      issue.wen        <= ctrl.wen;
      issue.mem_read   <= ctrl.mem_read;
      issue.mem_write  <= ctrl.mem_write;
      issue.mem_size   <= ctrl.mem_size;
      issue.illegal    <= ctrl.illegal;
    end
  end

  // the shared issue bus belongs to one unit per cycle
  a_one_unit: assert property (@(posedge CLK) disable iff (!nRST)
    !(arith_valid && lsu_valid));

endmodule

// ==== logic/credit_counter.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module credit_counter #(
  parameter int INIT_CREDITS = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  logic consume,
  input  logic give_back,
  output logic has_credit
);

  logic [`CREDIT_W-1:0] count;

  // a consume and a return in the same cycle leave the count alone
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= `CREDIT_W'(INIT_CREDITS);
    end else if (consume && !give_back) begin
      count <= count - 1'b1;
    end else if (give_back && !consume) begin
      count <= count + 1'b1;
    end
  end

  assign has_credit = (count != '0);

  // decode must stall rather than overrun the unit's queue
  a_no_overdraw: assert property (@(posedge CLK) disable iff (!nRST)
    consume |-> count != '0);

  // unit cannot retire more entries than it was handed
  a_no_excess_return: assert property (@(posedge CLK) disable iff (!nRST)
    give_back |-> count < `CREDIT_W'(INIT_CREDITS));

endmodule

// ==== logic/fence_fsm.sv ====
`timescale 1ns/1ps

module fence_fsm (
  input  logic CLK,
  input  logic nRST,
  input  logic accept,
  input  logic is_fence,
  input  logic icache_done,
  input  logic dcache_done,
  output logic flush_pulse,
  output logic run
);

  typedef enum logic [1:0] {
    RUN,
    FLUSH,
    WAIT
  } fence_state_e;

  fence_state_e state;
  fence_state_e next_state;
  logic         fence_start;
  logic         icache_seen;
  logic         dcache_seen;
  logic         out_of_reset;

  assign fence_start = (state == RUN) && accept && is_fence;

  always_comb begin
    next_state = state;
    case (state)
      RUN:     if (fence_start) next_state = FLUSH;
      FLUSH:   next_state = WAIT;
      WAIT:    if (icache_seen && dcache_seen) next_state = RUN;
      default: next_state = RUN;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state        <= RUN;
      out_of_reset <= 1'b0;
    end else begin
      state        <= next_state;
      out_of_reset <= 1'b1;
    end
  end

  // done pulses may come in either order, latch until the fsm returns to run
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      icache_seen <= 1'b0;
      dcache_seen <= 1'b0;
    end else if (fence_start) begin
      icache_seen <= 1'b0;
      dcache_seen <= 1'b0;
    end else begin
      if (icache_done) icache_seen <= 1'b1;
      if (dcache_done) dcache_seen <= 1'b1;
    end
  end

  assign flush_pulse = (state == FLUSH);
  assign run         = (state == RUN) && out_of_reset;

  // each fence gives both caches a single-cycle flush request
  a_flush_single: assert property (@(posedge CLK) disable iff (!nRST)
    flush_pulse |=> !flush_pulse);

endmodule

// ==== logic/operand_select.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module operand_select
  import decode_pkg::*;
(
  input  decode_ctrl_t       ctrl,
  input  logic [`XLEN_W-1:0] imm,
  input  logic [`XLEN_W-1:0] pc,
  input  logic [`XLEN_W-1:0] rs1_data,
  input  logic [`XLEN_W-1:0] rs2_data,
  output logic [`XLEN_W-1:0] port_a,
  output logic [`XLEN_W-1:0] port_b,
  output logic [`XLEN_W-1:0] store_data
);

  logic [`XLEN_W-1:0] shamt;

  // shift amount sits in the low bits of the i immediate
  assign shamt = {{(`XLEN_W-5){1'b0}}, imm[4:0]};

  always_comb begin
    case (ctrl.src_a)
      SRC_A_RS1:  port_a = rs1_data;
      SRC_A_PC:   port_a = pc;
      SRC_A_ZERO: port_a = '0;
      default:    port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.src_b)
      SRC_B_RS2:   port_b = rs2_data;
      SRC_B_IMM:   port_b = imm;
      SRC_B_SHAMT: port_b = shamt;
      default:     port_b = '0;
    endcase
  end

  // stores always carry rs2 alongside the address operands
  assign store_data = rs2_data;

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module instr_decoder
  import decode_pkg::*;
(
  input  instr_u             instr,
  output decode_ctrl_t       ctrl,
  output logic [`XLEN_W-1:0] imm
);

  // sub is only legal for register-register ops
  function automatic alu_op_e funct_to_alu(input logic [2:0] funct3,
                                           input logic       bit30,
                                           input logic       allow_sub);
    alu_op_e op;
    case (funct3)
      3'd0:    op = (allow_sub && bit30) ? SUB : ADD;
      3'd1:    op = SLL;
      3'd2:    op = SLT;
      3'd3:    op = SLTU;
      3'd4:    op = XOR;
      3'd5:    op = bit30 ? SRA : SRL;
      3'd6:    op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  logic [`XLEN_W-1:0] imm_i;
  logic [`XLEN_W-1:0] imm_s;
  logic [`XLEN_W-1:0] imm_u;
  logic               bit30;
  logic               is_shift;

  assign bit30 = instr.r_view.funct7[5];
  assign is_shift = (instr.r_view.funct3 == 3'd1) || (instr.r_view.funct3 == 3'd5);

  // sign-extended immediates
  assign imm_i = {{(`XLEN_W-12){instr.r_view.funct7[6]}}, instr.r_view.funct7,
                  instr.r_view.rs2};
  assign imm_s = {{(`XLEN_W-12){instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi,
                  instr.s_view.imm_lo};
  assign imm_u = {instr.r_view.funct7, instr.r_view.rs2, instr.r_view.rs1,
                  instr.r_view.funct3, 12'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.unit   = UNIT_ARITH;
    ctrl.alu_op = ADD;
    ctrl.src_a  = SRC_A_RS1;
    ctrl.src_b  = SRC_B_RS2;
    ctrl.rd     = instr.r_view.rd;
    imm         = '0;
    case (instr.r_view.opcode)
      `OPC_OP: begin
        ctrl.rs1    = instr.r_view.rs1;
        ctrl.rs2    = instr.r_view.rs2;
        ctrl.wen    = 1'b1;
        ctrl.alu_op = funct_to_alu(instr.r_view.funct3, bit30, 1'b1);
      end
      `OPC_OP_IMM: begin
        ctrl.rs1    = instr.r_view.rs1;
        ctrl.wen    = 1'b1;
        ctrl.src_b  = is_shift ? SRC_B_SHAMT : SRC_B_IMM;
        ctrl.alu_op = funct_to_alu(instr.r_view.funct3, bit30, 1'b0);
        imm         = imm_i;
      end
      `OPC_LOAD: begin
        ctrl.unit     = UNIT_LSU;
        ctrl.rs1      = instr.r_view.rs1;
        ctrl.wen      = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.mem_size = instr.r_view.funct3;
        ctrl.src_b    = SRC_B_IMM;
        imm           = imm_i;
      end
      `OPC_STORE: begin
        ctrl.unit      = UNIT_LSU;
        ctrl.rs1       = instr.s_view.rs1;
        ctrl.rs2       = instr.s_view.rs2;
        ctrl.rd        = '0;
        ctrl.mem_write = 1'b1;
        ctrl.mem_size  = instr.s_view.funct3;
        ctrl.src_b     = SRC_B_IMM;
        imm            = imm_s;
      end
      `OPC_LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.src_a = SRC_A_ZERO;
        ctrl.src_b = SRC_B_IMM;
        imm        = imm_u;
      end
      `OPC_AUIPC: begin
        ctrl.wen   = 1'b1;
        ctrl.src_a = SRC_A_PC;
        ctrl.src_b = SRC_B_IMM;
        imm        = imm_u;
      end
      `OPC_MISC_MEM: begin
        ctrl.is_fence = 1'b1;
        ctrl.rd       = '0;
      end
      default: begin
        // unknown opcode goes down the arithmetic path as an exception
        ctrl.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== logic/decode_pkg.sv ====
`include "decode_macros.svh"

package decode_pkg;

  // r-type field layout, also used for i-type and u-type
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_view_t;

  // store layout, immediate split around rs1/rs2
  typedef struct packed {
    logic [6:0]             imm_hi;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_lo;
    logic [6:0]             opcode;
  } s_view_t;

  typedef union packed {
    r_view_t r_view;
    s_view_t s_view;
  } instr_u;

  typedef enum logic {
    UNIT_ARITH = 1'b0,
    UNIT_LSU   = 1'b1
  } unit_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_A_RS1, SRC_A_PC, SRC_A_ZERO
  } src_a_e;

  typedef enum logic [1:0] {
    SRC_B_RS2, SRC_B_IMM, SRC_B_SHAMT
  } src_b_e;

  typedef struct packed {
    unit_e                  unit;
    alu_op_e                alu_op;
    src_a_e                 src_a;
    src_b_e                 src_b;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wen;
    logic                   mem_read;
    logic                   mem_write;
    logic [2:0]             mem_size;
    logic                   is_fence;
    logic                   illegal;
  } decode_ctrl_t;

  // one entry handed to either execution unit
  typedef struct packed {
    logic [`TAG_W-1:0]      tag;
    logic [`XLEN_W-1:0]     pc;
    logic [`XLEN_W-1:0]     port_a;
    logic [`XLEN_W-1:0]     port_b;
    logic [`XLEN_W-1:0]     store_data;
    alu_op_e                alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wen;
    logic                   mem_read;
    logic                   mem_write;
    logic [2:0]             mem_size;
    logic                   illegal;
  } issue_t;

endpackage

// ==== include/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath widths
`define XLEN_W      32
`define REG_ADDR_W  5
`define TAG_W       3

// credit counters toward the execution units
`define CREDIT_W       3
`define ARITH_CREDITS  4
`define LSU_CREDITS    2

// rv32i major opcodes handled by decode
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_MISC_MEM  7'b0001111

`endif
